// File: logic/fme_pkg.sv
// **********************************************************************
// widths, types and result structs shared by the fractional me cost rtl
// **********************************************************************

`default_nettype none

package fme_pkg;

    // **********************************************************************
    // widths and counts
    // **********************************************************************

    localparam int FMV_WIDTH    = 10;
    localparam int SATD_WIDTH   = 18;
    localparam int COST_WIDTH   = 19;
    localparam int LAMBDA_WIDTH = 7;
    localparam int MVBITS_WIDTH = 5;
    localparam int MVCOST_WIDTH = 13;
    localparam int SP_IDX_WIDTH = 4;
    localparam int NUM_SP       = 9;

    // longest exp-golomb code for a 10 bit difference
    localparam int MVBITS_MAX   = 21;

    // **********************************************************************
    // scalar types
    // **********************************************************************

    // motion vector component or difference, in fractional pel units
    typedef logic signed [FMV_WIDTH-1:0] fmv_t;

    typedef logic [SATD_WIDTH-1:0]   satd_t;
    // accumulated cost, wraps modulo 2^19
    typedef logic [COST_WIDTH-1:0]   cost_t;
    typedef logic [LAMBDA_WIDTH-1:0] lambda_t;
    // bits of one mvd component, 1 to 21
    typedef logic [MVBITS_WIDTH-1:0] mvbits_t;
    // lambda times x plus y bits
    typedef logic [MVCOST_WIDTH-1:0] mvcost_t;
    // search point 0..8
    typedef logic [SP_IDX_WIDTH-1:0] sp_idx_t;

    // **********************************************************************
    // bundles
    // **********************************************************************

    // one beat of satd, satd[k] for point k = 3*(y+1) + (x+1)
    typedef struct packed {
        satd_t [NUM_SP-1:0] satd;
        logic               last;
    } satd_beat_t;

    typedef struct packed {
        fmv_t    best_x;
        fmv_t    best_y;
        sp_idx_t best_sp;
        cost_t   best_cost;
    } fme_result_t;

    typedef enum logic {
        IDLE,
        ACCUM
    } accum_state_t;

endpackage

`default_nettype wire

// File: logic/mvd_bits.sv
// **********************************************************************
// exp-golomb length of one signed mvd component, combinational
// **********************************************************************

`default_nettype none

module mvd_bits import fme_pkg::*; (
    input  fmv_t    mvd_i,
    output mvbits_t bits_o
);

    logic                 neg;
    logic [FMV_WIDTH-1:0] mag;
    // code number plus one, 11 bits so that -512 still fits
    logic [FMV_WIDTH:0]   code_p1;
    logic [3:0]           msb;
    mvbits_t              len;

    assign neg = mvd_i[FMV_WIDTH-1];
    assign mag = neg ? -mvd_i : mvd_i;

    // positive v -> 2v + 1, negative v -> 2|v|, zero -> 1
    assign code_p1 = neg ? {mag, 1'b0} : {mag, 1'b1};

    // leading one position
    always_comb begin
        msb = '0;
        for (int i = 0; i <= FMV_WIDTH; i++) begin
            if (code_p1[i]) begin
                msb = 4'(i);
            end
        end
    end

    // 2*floor(log2) + 1
    assign len = {msb, 1'b1};

    assign bits_o = (len > mvbits_t'(MVBITS_MAX)) ? mvbits_t'(MVBITS_MAX) : len;

endmodule

`default_nettype wire

// File: logic/mv_cost_gen.sv
// **********************************************************************
// nine motion vector costs around the centre vector, captured on start
// and held for the whole run together with the centre and step size
// **********************************************************************

`default_nettype none

module mv_cost_gen import fme_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start_i,
    input  fmv_t                     mv_x_i,
    input  fmv_t                     mv_y_i,
    input  logic                     half_i,
    input  lambda_t                  lambda_i,
    output mvcost_t [NUM_SP-1:0]     mvcost_o,
    output fmv_t                     center_x_o,
    output fmv_t                     center_y_o,
    output logic                     half_o
);

    fmv_t                 step;
    fmv_t                 dx [3];
    fmv_t                 dy [3];
    mvbits_t              bits_x [3];
    mvbits_t              bits_y [3];
    mvcost_t [NUM_SP-1:0] mvcost_d;

    // **********************************************************************
    // mvd per axis, predictor is zero
    // **********************************************************************

    // 2 for half-pel, 1 for quarter-pel
    assign step = half_i ? fmv_t'(2) : fmv_t'(1);

    assign dx[0] = mv_x_i - step;
    assign dx[1] = mv_x_i;
    assign dx[2] = mv_x_i + step;
    assign dy[0] = mv_y_i - step;
    assign dy[1] = mv_y_i;
    assign dy[2] = mv_y_i + step;

    for (genvar k = 0; k < 3; k++) begin : g_axis
        mvd_bits u_bits_x (
            .mvd_i  (dx[k]),
            .bits_o (bits_x[k])
        );
        mvd_bits u_bits_y (
            .mvd_i  (dy[k]),
            .bits_o (bits_y[k])
        );
    end

    // **********************************************************************
    // lambda * (bits_x + bits_y), row-major with y outer
    // **********************************************************************

    always_comb begin
        mvcost_t bsum;
        bsum = '0;
        for (int j = 0; j < 3; j++) begin
            for (int i = 0; i < 3; i++) begin
                bsum = mvcost_t'(bits_x[i]) + mvcost_t'(bits_y[j]);
                // max 42 * 127 still fits 13 bits
                mvcost_d[3*j+i] = bsum * mvcost_t'(lambda_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            mvcost_o   <= mvcost_d;
            center_x_o <= mv_x_i;
            center_y_o <= mv_y_i;
            half_o     <= half_i;
        end
    end

    // a zero lambda would make the search ignore the vector cost
    a_lambda_nonzero: assert property (
        @(posedge clk) disable iff (!rstn) start_i |-> (lambda_i != '0)
    );

endmodule

`default_nettype wire

// File: logic/cost_accum.sv
// **********************************************************************
// nine search point cost accumulators, satd per beat plus mv cost once
// on the last beat, with a one-cycle sums_valid when the run ends
// **********************************************************************

`default_nettype none

module cost_accum import fme_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start_i,
    input  logic                 beat_valid_i,
    input  satd_beat_t           satd_beat_i,
    input  mvcost_t [NUM_SP-1:0] mvcost_i,
    output cost_t [NUM_SP-1:0]   sums_o,
    output logic                 sums_valid_o
);

    accum_state_t       state;
    logic               beat_acc;
    logic               beat_last;
    cost_t [NUM_SP-1:0] sums_d;

    assign beat_acc  = beat_valid_i && (state == ACCUM);
    assign beat_last = beat_acc && satd_beat_i.last;

    // **********************************************************************
    // run fsm
    // **********************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= IDLE;
            sums_valid_o <= 1'b0;
        end else begin
            sums_valid_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= ACCUM;
                    end
                end
                ACCUM: begin
                    if (beat_last) begin
                        state        <= IDLE;
                        sums_valid_o <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // **********************************************************************
    // accumulators
    // **********************************************************************

    // mv cost enters once per partition, on the last beat
    always_comb begin
        for (int i = 0; i < NUM_SP; i++) begin
            sums_d[i] = sums_o[i] + cost_t'(satd_beat_i.satd[i]);
            if (satd_beat_i.last) begin
                sums_d[i] = sums_d[i] + cost_t'(mvcost_i[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            sums_o <= '0;
        end else if (beat_acc) begin
            sums_o <= sums_d;
        end
    end

    // beats only belong to a started run
    a_no_beat_idle: assert property (
        @(posedge clk) disable iff (!rstn) (state == IDLE) |-> !beat_valid_i
    );

    // one run at a time, no restart before the last beat
    a_no_start_accum: assert property (
        @(posedge clk) disable iff (!rstn) (state == ACCUM) |-> !start_i
    );

endmodule

`default_nettype wire

// File: logic/best_sp_select.sv
// **********************************************************************
// fixed comparison tree over the nine search point costs that registers
// the best point with its cost and refined vector one cycle after sums_valid
// **********************************************************************

`default_nettype none

module best_sp_select import fme_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  cost_t [NUM_SP-1:0] sums_i,
    input  logic               sums_valid_i,
    input  fmv_t               center_x_i,
    input  fmv_t               center_y_i,
    input  logic               half_i,
    output logic               result_valid_o,
    output fme_result_t        result_o
);

    typedef struct packed {
        cost_t   cost;
        sp_idx_t idx;
    } sp_cand_t;

    // ties go to r because l is kept only when strictly cheaper
    function automatic sp_cand_t pick(input sp_cand_t l, input sp_cand_t r);
        return (l.cost < r.cost) ? l : r;
    endfunction

    sp_cand_t          cand [NUM_SP];
    sp_cand_t          w01;
    sp_cand_t          w25;
    sp_cand_t          w34;
    sp_cand_t          w67;
    sp_cand_t          w0134;
    sp_cand_t          w2567;
    sp_cand_t          w_tree;
    sp_cand_t          best;
    logic signed [1:0] off_x;
    logic signed [1:0] off_y;
    fmv_t              dx;
    fmv_t              dy;

    always_comb begin
        for (int i = 0; i < NUM_SP; i++) begin
            cand[i].cost = sums_i[i];
            cand[i].idx  = sp_idx_t'(i);
        end
    end

    // **********************************************************************
    // comparison tree
    // **********************************************************************

    assign w01   = pick(cand[0], cand[1]);
    assign w25   = pick(cand[2], cand[5]);
    assign w34   = pick(cand[3], cand[4]);
    assign w67   = pick(cand[6], cand[7]);

    assign w0134 = pick(w01, w34);
    assign w2567 = pick(w25, w67);

    // second winner must be strictly cheaper to take over
    assign w_tree = pick(w2567, w0134);

    // point 8 challenges the tree winner last
    assign best   = pick(cand[8], w_tree);

    // **********************************************************************
    // offset of the winner in steps
    // **********************************************************************

    always_comb begin
        case (best.idx)
            4'd0, 4'd3, 4'd6: off_x = -2'sd1;
            4'd1, 4'd4, 4'd7: off_x = 2'sd0;
            default:          off_x = 2'sd1;
        endcase
        case (best.idx)
            4'd0, 4'd1, 4'd2: off_y = -2'sd1;
            4'd3, 4'd4, 4'd5: off_y = 2'sd0;
            default:          off_y = 2'sd1;
        endcase
    end

    // half-pel steps are two quarter-pel units
    assign dx = half_i ? (fmv_t'(off_x) <<< 1) : fmv_t'(off_x);
    assign dy = half_i ? (fmv_t'(off_y) <<< 1) : fmv_t'(off_y);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            result_valid_o <= sums_valid_i;
            if (sums_valid_i) begin
                result_o.best_x    <= center_x_i + dx;
                result_o.best_y    <= center_y_i + dy;
                result_o.best_sp   <= best.idx;
                result_o.best_cost <= best.cost;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fme_cost_top.sv
// **********************************************************************
// fractional me cost engine, start a run then stream satd beats and
// collect the best of nine search points two cycles after the last beat
// **********************************************************************

`default_nettype none

module fme_cost_top import fme_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        start_i,
    input  fmv_t        mv_x_i,
    input  fmv_t        mv_y_i,
    input  logic        half_i,
    input  lambda_t     lambda_i,
    input  logic        beat_valid_i,
    input  satd_beat_t  satd_beat_i,
    output logic        result_valid_o,
    output fme_result_t result_o
);

    mvcost_t [NUM_SP-1:0] mvcost;
    fmv_t                 center_x;
    fmv_t                 center_y;
    logic                 half_run;
    cost_t [NUM_SP-1:0]   sums;
    logic                 sums_valid;

    // mv costs and run context, held from start
    mv_cost_gen u_mv_cost_gen (
        .clk        (clk),
        .rstn       (rstn),
        .start_i    (start_i),
        .mv_x_i     (mv_x_i),
        .mv_y_i     (mv_y_i),
        .half_i     (half_i),
        .lambda_i   (lambda_i),
        .mvcost_o   (mvcost),
        .center_x_o (center_x),
        .center_y_o (center_y),
        .half_o     (half_run)
    );

    cost_accum u_cost_accum (
        .clk          (clk),
        .rstn         (rstn),
        .start_i      (start_i),
        .beat_valid_i (beat_valid_i),
        .satd_beat_i  (satd_beat_i),
        .mvcost_i     (mvcost),
        .sums_o       (sums),
        .sums_valid_o (sums_valid)
    );

    best_sp_select u_best_sp_select (
        .clk            (clk),
        .rstn           (rstn),
        .sums_i         (sums),
        .sums_valid_i   (sums_valid),
        .center_x_i     (center_x),
        .center_y_i     (center_y),
        .half_i         (half_run),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

// File: verification/fme_ref_model.svh
// **********************************************************************
// reference model of the cost rules, included inside the testbench module
// **********************************************************************

`ifndef FME_REF_MODEL_SVH
`define FME_REF_MODEL_SVH

// sign-wrap to the vector width
function automatic int wrap_mv(input int v);
    return int'(fmv_t'(v));
endfunction

function automatic int step_size(input bit half);
    return half ? 2 : 1;
endfunction

// point k sits in column k%3 and row k/3 of the grid
function automatic int offset_x(input int k);
    return (k % 3) - 1;
endfunction

function automatic int offset_y(input int k);
    return (k / 3) - 1;
endfunction

// ue code number first, then 2*floor(log2(code+1)) + 1, capped at 21
function automatic int expgolomb_len(input int v);
    int code;
    int lg;
    code = (v > 0) ? 2 * v : ((v < 0) ? -2 * v - 1 : 0);
    lg = 0;
    while (((code + 1) >> (lg + 1)) != 0) begin
        lg++;
    end
    return (2 * lg + 1 > 21) ? 21 : 2 * lg + 1;
endfunction

// predictor is zero, so the mvd is the candidate vector itself
function automatic int point_mvcost(input int cx, input int cy, input bit half,
                                    input int lam, input int k);
    int bx;
    int by;
    bx = expgolomb_len(wrap_mv(cx + step_size(half) * offset_x(k)));
    by = expgolomb_len(wrap_mv(cy + step_size(half) * offset_y(k)));
    return (bx + by) * lam;
endfunction

function automatic int refined_mv(input int c, input bit half, input int off);
    return wrap_mv(c + step_size(half) * off);
endfunction

// left survives only when strictly cheaper
function automatic int keep_left(input int l, input int r, input int cost [NUM_SP]);
    return (cost[l] < cost[r]) ? l : r;
endfunction

function automatic int tree_best(input int cost [NUM_SP]);
    int w0134;
    int w2567;
    int w_tree;
    w0134  = keep_left(keep_left(0, 1, cost), keep_left(3, 4, cost), cost);
    w2567  = keep_left(keep_left(2, 5, cost), keep_left(6, 7, cost), cost);
    // second winner takes over only when strictly cheaper
    w_tree = keep_left(w2567, w0134, cost);
    return keep_left(8, w_tree, cost);
endfunction

`endif

// File: verification/tb_fme_cost.sv
// **********************************************************************
// random and directed runs of the me cost engine against a reference model
// **********************************************************************

`default_nettype none

module tb_fme_cost import fme_pkg::*; ();

    localparam int MAX_BEATS   = 16;
    localparam int CYCLE_LIMIT = 200 * 40;

    logic        clk;
    logic        rstn;
    logic        start_i;
    fmv_t        mv_x_i;
    fmv_t        mv_y_i;
    logic        half_i;
    lambda_t     lambda_i;
    logic        beat_valid_i;
    satd_beat_t  satd_beat_i;
    logic        result_valid_o;
    fme_result_t result_o;

    integer seed;
    int     errors = 0;
    int     monitor_errors = 0;
    int     checks = 0;
    int     runs_done = 0;
    int     pulses = 0;
    int     cycles = 0;
    logic   prev_valid = 1'b0;
    int     nbeats;
    satd_t  beat_satd [MAX_BEATS][NUM_SP];

    `include "fme_ref_model.svh"

    fme_cost_top DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // result pulses, counted and checked for width
    always @(negedge clk) begin
        if (rstn && result_valid_o) begin
            pulses++;
            assert (!prev_valid) else begin
                $display("result_valid_o stayed high for more than one cycle");
                monitor_errors++;
            end
        end
        prev_valid = result_valid_o;
    end

    task automatic compare_field(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic junk_beat();
        beat_valid_i = 1'b0;
        for (int k = 0; k < NUM_SP; k++) begin
            satd_beat_i.satd[k] = satd_t'($random(seed));
        end
        satd_beat_i.last = 1'($random(seed));
    endtask

    // **********************************************************************
    // one run: start, beats from beat_satd, result check
    // **********************************************************************

    task automatic drive_run(input int cx, input int cy, input bit half,
                             input int lam, input int max_gap);
        int   sum_satd [NUM_SP];
        int   want_cost [NUM_SP];
        int   best;
        int   gap;
        int   waited;
        logic seen;
        for (int k = 0; k < NUM_SP; k++) begin
            sum_satd[k] = 0;
        end
        @(posedge clk);
        #1;
        start_i  = 1'b1;
        mv_x_i   = fmv_t'(cx);
        mv_y_i   = fmv_t'(cy);
        half_i   = half;
        lambda_i = lambda_t'(lam);
        @(posedge clk);
        #1;
        // inputs only count on the start cycle
        start_i  = 1'b0;
        mv_x_i   = fmv_t'($random(seed));
        mv_y_i   = fmv_t'($random(seed));
        half_i   = ~half;
        lambda_i = lambda_t'($random(seed));
        @(posedge clk);
        #1;
        for (int b = 0; b < nbeats; b++) begin
            gap = ($random(seed) & 32'h7fff_ffff) % (max_gap + 1);
            repeat (gap) begin
                junk_beat();
                @(posedge clk);
                #1;
            end
            beat_valid_i     = 1'b1;
            satd_beat_i.last = (b == nbeats - 1);
            for (int k = 0; k < NUM_SP; k++) begin
                satd_beat_i.satd[k] = beat_satd[b][k];
                sum_satd[k] += int'(beat_satd[b][k]);
            end
            @(posedge clk);
            #1;
        end
        junk_beat();
        // result due on the second edge after the last beat
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 8) begin
            @(negedge clk);
            waited++;
            seen = result_valid_o;
        end
        assert (seen) else begin
            $display("no result_valid_o pulse within 8 cycles of the last beat");
            errors++;
        end
        compare_field("result_valid_o latency", waited, 2);
        for (int k = 0; k < NUM_SP; k++) begin
            want_cost[k] = (sum_satd[k] + point_mvcost(cx, cy, half, lam, k)) & 32'h7_ffff;
        end
        best = tree_best(want_cost);
        compare_field("best_cost", int'(result_o.best_cost), want_cost[best]);
        compare_field("best_sp", int'(result_o.best_sp), best);
        compare_field("best_x", int'($signed(result_o.best_x)),
                      refined_mv(cx, half, offset_x(best)));
        compare_field("best_y", int'($signed(result_o.best_y)),
                      refined_mv(cy, half, offset_y(best)));
        runs_done++;
    endtask

    // **********************************************************************
    // tests
    // **********************************************************************

    task automatic idle_after_reset();
        repeat (8) begin
            @(negedge clk);
            compare_field("result_valid_o", int'(result_valid_o), 0);
            assert (result_o == '0) else begin
                $display("[FAIL] result_o got %h expected %h", result_o, 43'h0);
                errors++;
            end
        end
    endtask

    task automatic random_runs(input bit half, input int count);
        int cx;
        int cy;
        int lam;
        for (int r = 0; r < count; r++) begin
            // mostly near zero, now and then anywhere in range
            if (($random(seed) & 7) == 0) begin
                cx = wrap_mv($random(seed));
                cy = wrap_mv($random(seed));
            end else begin
                cx = $random(seed) % 200;
                cy = $random(seed) % 200;
            end
            lam    = 1 + (($random(seed) & 32'h7fff_ffff) % 127);
            nbeats = 1 + ($random(seed) & 15);
            for (int b = 0; b < nbeats; b++) begin
                for (int k = 0; k < NUM_SP; k++) begin
                    beat_satd[b][k] = satd_t'($random(seed) & 32'h3fff);
                end
            end
            drive_run(cx, cy, half, lam, 1);
            repeat ($random(seed) & 3) @(posedge clk);
        end
    endtask

    // low_a below zero makes every point equal
    task automatic tie_case(input int low_a, input int low_b, input int want_sp);
        int cx;
        int cy;
        int lam;
        int target;
        bit half;
        cx     = $random(seed) % 100;
        cy     = $random(seed) % 100;
        lam    = 1 + (($random(seed) & 32'h7fff_ffff) % 127);
        half   = 1'($random(seed));
        nbeats = 1;
        // single last beat, so each sum is satd plus mv cost
        for (int k = 0; k < NUM_SP; k++) begin
            target = (low_a < 0 || k == low_a || k == low_b) ? 30000 : 30100;
            beat_satd[0][k] = satd_t'(target - point_mvcost(cx, cy, half, lam, k));
        end
        drive_run(cx, cy, half, lam, 0);
        compare_field("best_sp", int'(result_o.best_sp), want_sp);
    endtask

    task automatic tie_runs();
        tie_case(-1, -1, 4);
        tie_case(0, 1, 1);
        tie_case(2, 6, 6);
        tie_case(3, 8, 3);
        tie_case(5, 1, 1);
        tie_case(8, 8, 8);
    endtask

    // long heavy runs alternate with short light ones, no idle between
    task automatic back_to_back_runs();
        for (int r = 0; r < 6; r++) begin
            nbeats = (r % 2 == 0) ? MAX_BEATS : 1;
            for (int b = 0; b < nbeats; b++) begin
                for (int k = 0; k < NUM_SP; k++) begin
                    beat_satd[b][k] = (r % 2 == 0) ?
                        satd_t'(($random(seed) & 32'h0fff) | 32'h3000) :
                        satd_t'($random(seed) & 32'hff);
                end
            end
            drive_run($random(seed) % 64, $random(seed) % 64, 1'(r / 2), 1 + r * 20, 0);
        end
    endtask

    task automatic report_done(input string name, input int runs0, input int errs0);
        $display("test %-14s runs %0d errors %0d", name, runs_done - runs0, errors - errs0);
    endtask

    initial begin
        int runs0;
        int errs0;
        seed         = 32'h8236_5a98;
        rstn         = 1'b0;
        start_i      = 1'b0;
        mv_x_i       = '0;
        mv_y_i       = '0;
        half_i       = 1'b0;
        lambda_i     = '0;
        beat_valid_i = 1'b0;
        satd_beat_i  = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        runs0 = runs_done;
        errs0 = errors;
        idle_after_reset();
        report_done("reset_idle", runs0, errs0);
        runs0 = runs_done;
        errs0 = errors;
        random_runs(1'b1, 90);
        report_done("random_half", runs0, errs0);
        runs0 = runs_done;
        errs0 = errors;
        random_runs(1'b0, 90);
        report_done("random_quarter", runs0, errs0);
        runs0 = runs_done;
        errs0 = errors;
        tie_runs();
        report_done("ties", runs0, errs0);
        runs0 = runs_done;
        errs0 = errors;
        back_to_back_runs();
        report_done("back_to_back", runs0, errs0);

        repeat (4) @(posedge clk);
        compare_field("result_valid_o pulses", pulses, runs_done);
        errors = errors + monitor_errors;
        $display("summary: runs %0d checks %0d errors %0d", runs_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
logic/fme_pkg.sv
logic/mvd_bits.sv
logic/mv_cost_gen.sv
logic/cost_accum.sv
logic/best_sp_select.sv
logic/fme_cost_top.sv
verification/tb_fme_cost.sv

// File: Makefile
SIM := obj_dir/Vtb_fme_cost

all: run

$(SIM): sources.f $(wildcard logic/*.sv) $(wildcard verification/*.sv verification/*.svh)
	verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_fme_cost

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: all run clean
